//--- Makefile
VERILATOR ?= verilator
TOP       ?= patternSearch_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	-$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx '$(PASS_TEXT)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/patternSearch_asserts.sv
module patternSearch_asserts (
    input logic clock,
    input logic reset_N,
    input logic busy,
    input logic done,
    input logic found,
    input logic error
);

    int unsigned violations = 0;                    // Polled by the testbench at the end

    doneSingle: assert property (@(posedge clock) disable iff (!reset_N) done |=> !done)
        else begin
            violations = violations + 1;
            $error("done stayed high for more than one cycle");
        end

    doneInBusy: assert property (@(posedge clock) disable iff (!reset_N) done |-> busy)
        else begin
            violations = violations + 1;
            $error("done pulsed while busy was low");
        end

    resultExclusive: assert property (@(posedge clock) disable iff (!reset_N) !(found && error))
        else begin
            violations = violations + 1;
            $error("found and error were high together");
        end

    // Sequencer must sit in idle once reset has been seen
    idleAfterReset: assert property (@(posedge clock) !reset_N |=> !busy)
        else begin
            violations = violations + 1;
            $error("busy was high right after reset");
        end

endmodule

bind patternSearch patternSearch_asserts checks (
    .clock(clock),
    .reset_N(reset_N),
    .busy(busy),
    .done(done),
    .found(found),
    .error(error)
);

//--- bench/patternSearch_tb.sv
module patternSearch_tb import dnaPkg::*; ();

    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 8;
    localparam int SEED = 87110;
    localparam int LITERAL_RUNS = 20;
    localparam int SET_RUNS = 20;
    localparam int MISS_RUNS = 10;
    localparam int BAD_RUNS = 4;
    localparam int SEARCH_COUNT = LITERAL_RUNS + SET_RUNS + MISS_RUNS + BAD_RUNS + 2;
    localparam int SEARCH_BUDGET = 2 * SEQ_DEPTH * PAT_DEPTH + SEQ_DEPTH + PAT_DEPTH + 64;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + SEARCH_COUNT * SEARCH_BUDGET;

    logic    clock = 1'b0;
    logic    reset_N;
    logic    start;
    seqLenT  seqLength;
    logic    seqWrite;
    seqAddrT seqAddr;
    baseT    seqData;
    logic    patWrite;
    patAddrT patAddr;
    tokenT   patData;
    logic    busy;
    logic    done;
    logic    found;
    logic    error;
    seqAddrT matchOffset;

    baseT   seqMem [SEQ_DEPTH];                     // Image of the sequence store
    tokenT  patMem [PAT_DEPTH];
    seqLenT curLength;

    patternSearch UUT (
        .clock(clock),
        .reset_N(reset_N),
        .start(start),
        .seqLength(seqLength),
        .seqWrite(seqWrite),
        .seqAddr(seqAddr),
        .seqData(seqData),
        .patWrite(patWrite),
        .patAddr(patAddr),
        .patData(patData),
        .busy(busy),
        .done(done),
        .found(found),
        .error(error),
        .matchOffset(matchOffset)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED %s expected %0b actual %0b", name, expected, actual));
        end
    endtask

    task automatic checkOffset(input string name, input seqAddrT expected, input seqAddrT actual);
        if (actual !== expected) begin
            abortRun($sformatf("CHECK FAILED %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    function automatic baseT randomBase();
        return baseT'($urandom_range(3, 0));
    endfunction

    function automatic logic validBase(baseT b);
        return b <= 3'd3;
    endfunction

    function automatic logic tokenBad(tokenT t);
        case (t.kind)
            literal: return !validBase(t.first);
            pairSet: return !validBase(t.first) || !validBase(t.second) || t.first == t.second;
            tripleSet: return !validBase(t.first) || !validBase(t.second) || !validBase(t.third)
                              || t.first == t.second || t.first == t.third
                              || t.second == t.third;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic tokenTakes(tokenT t, baseT b);
        case (t.kind)
            literal: return b == t.first;
            pairSet: return b == t.first || b == t.second;
            tripleSet: return b == t.first || b == t.second || b == t.third;
            default: return 1'b0;
        endcase
    endfunction

    // Fields are always distinct, so any kind comes out well formed
    function automatic tokenT randomToken(tokenKindT kind);
        tokenT t;
        t.kind  = kind;
        t.first = randomBase();
        do t.second = randomBase(); while (t.second == t.first);
        do t.third = randomBase(); while (t.third == t.first || t.third == t.second);
        return t;
    endfunction

    function automatic baseT pickAccepted(tokenT t);
        int pick;
        pick = $urandom_range(2, 0);
        if (t.kind == literal || pick == 0) begin
            return t.first;
        end else if (t.kind == pairSet || pick == 1) begin
            return t.second;
        end
        return t.third;
    endfunction

    task automatic clearPattern();
        for (int i = 0; i < PAT_DEPTH; i++) begin
            patMem[i] = '{kind: patEnd, first: BASE_A, second: BASE_A, third: BASE_A};
        end
    endtask

    task automatic randomSequence(input int len);
        curLength = seqLenT'(len);
        for (int i = 0; i < SEQ_DEPTH; i++) begin
            seqMem[i] = randomBase();
        end
    endtask

    task automatic plantPattern(input int count, input int at);
        for (int i = 0; i < count; i++) begin
            seqMem[at + i] = pickAccepted(patMem[i]);
        end
    endtask

    task automatic loadMemories();
        for (int i = 0; i < SEQ_DEPTH; i++) begin
            @(posedge clock);
            seqWrite <= 1'b1;
            seqAddr  <= seqAddrT'(i);
            seqData  <= seqMem[i];
            patWrite <= i < PAT_DEPTH;
            patAddr  <= patAddrT'(i);
            patData  <= patMem[i % PAT_DEPTH];
        end
        @(posedge clock);
        seqWrite <= 1'b0;
        patWrite <= 1'b0;
    endtask

    // Offset by offset, token by token, first match wins
    task automatic runModel(output logic expFound, output logic expError,
                            output seqAddrT expOffset);
        int   off;
        int   idx;
        logic running;
        expFound  = 1'b0;
        expError  = 1'b0;
        expOffset = '0;
        off       = 0;
        idx       = 0;
        running   = 1'b1;
        while (running) begin
            if (patMem[idx].kind == patEnd) begin
                expFound  = 1'b1;
                expOffset = seqAddrT'(off);
                running   = 1'b0;
            end else if (tokenBad(patMem[idx])) begin
                expError = 1'b1;
                running  = 1'b0;
            end else if (off + idx >= curLength) begin
                running = 1'b0;
            end else if (!validBase(seqMem[off + idx])) begin
                expError = 1'b1;
                running  = 1'b0;
            end else if (!tokenTakes(patMem[idx], seqMem[off + idx])) begin
                off = off + 1;
                idx = 0;
            end else if (idx == PAT_DEPTH - 1) begin
                expError = 1'b1;                    // No end token in any slot
                running  = 1'b0;
            end else begin
                idx = idx + 1;
            end
        end
    endtask

    task automatic runSearch(input string name);
        logic    expFound;
        logic    expError;
        seqAddrT expOffset;
        logic    gotFound;
        logic    gotError;
        seqAddrT gotOffset;
        int      doneSeen;
        loadMemories();
        runModel(expFound, expError, expOffset);
        @(negedge clock);
        checkFlag({name, " busy before start"}, 1'b0, busy);
        @(posedge clock);
        start     <= 1'b1;
        seqLength <= curLength;
        @(posedge clock);
        start <= 1'b0;
        doneSeen  = 0;
        gotFound  = 1'b0;
        gotError  = 1'b0;
        gotOffset = '0;
        @(negedge clock);
        while (busy) begin
            if (done) begin
                doneSeen  = doneSeen + 1;
                gotFound  = found;
                gotError  = error;
                gotOffset = matchOffset;
            end
            @(negedge clock);
        end
        if (done) begin
            doneSeen = doneSeen + 1;                // Stray pulse after busy fell
        end
        if (doneSeen != 1) begin
            abortRun($sformatf("%s: done pulsed %0d times instead of once", name, doneSeen));
        end
        checkFlag({name, " found"}, expFound, gotFound);
        checkFlag({name, " error"}, expError, gotError);
        checkOffset({name, " matchOffset"}, expOffset, gotOffset);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        abortRun($sformatf("Watchdog expired after %0d cycles without finishing", WATCHDOG_CYCLES));
    end

    initial begin
        int k;
        int len;
        int at;
        int slot;
        void'($urandom(SEED));
        reset_N   = 1'b0;
        start     = 1'b0;
        seqLength = '0;
        seqWrite  = 1'b0;
        seqAddr   = '0;
        seqData   = BASE_A;
        patWrite  = 1'b0;
        patAddr   = '0;
        patData   = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset_N <= 1'b1;

        for (int run = 0; run < LITERAL_RUNS; run++) begin
            k   = $urandom_range(6, 1);
            len = $urandom_range(SEQ_DEPTH, k);
            at  = $urandom_range(len - k, 0);
            randomSequence(len);
            clearPattern();
            for (int i = 0; i < k; i++) begin
                patMem[i] = randomToken(literal);
            end
            plantPattern(k, at);
            runSearch($sformatf("literal run %0d", run));
        end

        for (int run = 0; run < SET_RUNS; run++) begin
            k   = $urandom_range(6, 1);
            len = $urandom_range(SEQ_DEPTH, k);
            at  = $urandom_range(len - k, 0);
            randomSequence(len);
            clearPattern();
            for (int i = 0; i < k; i++) begin
                patMem[i] = randomToken(tokenKindT'($urandom_range(2, 0)));
            end
            plantPattern(k, at);
            runSearch($sformatf("set run %0d", run));
        end

        for (int run = 0; run < MISS_RUNS; run++) begin
            randomSequence($urandom_range(SEQ_DEPTH, 8));
            clearPattern();
            for (int i = 0; i < PAT_DEPTH - 1; i++) begin
                patMem[i] = randomToken(literal);
            end
            runSearch($sformatf("miss run %0d", run));
        end

        // Fault sits at slot j of a copy planted at offset 0
        for (int run = 0; run < BAD_RUNS; run++) begin
            k   = $urandom_range(5, 2);
            len = $urandom_range(SEQ_DEPTH, k);
            randomSequence(len);
            clearPattern();
            for (int i = 0; i < k; i++) begin
                patMem[i] = randomToken(tokenKindT'($urandom_range(2, 0)));
            end
            plantPattern(k, 0);
            slot = $urandom_range(k - 1, 0);
            if (run == 0) begin
                patMem[slot].kind   = pairSet;
                patMem[slot].second = patMem[slot].first;
            end else if (run == 1) begin
                patMem[slot].kind  = tripleSet;
                patMem[slot].third = patMem[slot].second;
            end else begin
                seqMem[slot] = baseT'($urandom_range(7, 4));
            end
            runSearch($sformatf("fault run %0d", run));
        end

        randomSequence($urandom_range(SEQ_DEPTH, 1));
        clearPattern();
        runSearch("empty pattern");

        randomSequence(4);
        clearPattern();
        for (int i = 0; i < 6; i++) begin
            patMem[i] = randomToken(literal);
        end
        plantPattern(4, 0);                         // Prefix fits, tail runs off the end
        runSearch("long pattern");

        if (UUT.checks.violations == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
src/dnaPkg.sv
src/symbolStore.sv
src/tokenDecoder.sv
src/matchSequencer.sv
src/patternSearch.sv
bench/patternSearch_asserts.sv
bench/patternSearch_tb.sv

//--- src/dnaPkg.sv
package dnaPkg;

    localparam int SEQ_DEPTH = 32;
    localparam int PAT_DEPTH = 8;
    localparam int SEQ_ADDR_W = $clog2(SEQ_DEPTH);
    localparam int PAT_ADDR_W = $clog2(PAT_DEPTH);

    typedef logic [2:0] baseT;

    localparam baseT BASE_A = 3'd0;
    localparam baseT BASE_C = 3'd1;
    localparam baseT BASE_T = 3'd2;
    localparam baseT BASE_G = 3'd3;

    typedef enum logic [1:0] {literal, pairSet, tripleSet, patEnd} tokenKindT;

    typedef struct packed {
        tokenKindT kind;
        baseT      first;
        baseT      second;
        baseT      third;
    } tokenT;

    typedef logic [3:0] baseMaskT;                  // Bit per base, A in bit 0
    typedef logic [SEQ_ADDR_W-1:0] seqAddrT;
    typedef logic [PAT_ADDR_W-1:0] patAddrT;
    typedef logic [SEQ_ADDR_W:0] seqLenT;           // 0 to SEQ_DEPTH

    // Token-sized payloads live in the pattern store, everything else in the sequence
    function automatic int storeAddrBits(int payloadBits);
        return (payloadBits == $bits(tokenT)) ? PAT_ADDR_W : SEQ_ADDR_W;
    endfunction

    function automatic baseMaskT baseBit(baseT b);
        case (b)
            BASE_A: return 4'b0001;
            BASE_C: return 4'b0010;
            BASE_T: return 4'b0100;
            BASE_G: return 4'b1000;
            default: return '0;                     // Invalid code
        endcase
    endfunction

    function automatic logic isBase(baseT b);
        return baseBit(b) != '0;
    endfunction

endpackage

//--- src/matchSequencer.sv
module matchSequencer import dnaPkg::*; (
    input  logic      clock,
    input  logic      reset_N,
    input  logic      start,
    input  seqLenT    seqLength,
    output seqAddrT   seqReadAddr,
    input  baseT      seqSymbol,
    output patAddrT   patReadAddr,
    input  tokenKindT tokenKind,
    input  baseMaskT  acceptMask,
    input  logic      malformed,
    output logic      busy,
    output logic      done,
    output logic      found,
    output logic      error,
    output seqAddrT   matchOffset
);

    typedef enum logic [2:0] {
        idle,
        fetch,
        compare,
        nextOffset,
        finish
    } stateT;

    stateT   state;
    stateT   nextState;
    seqLenT  lengthReg;                             // Length sampled at start
    seqLenT  offset;
    patAddrT index;
    seqLenT  position;
    logic    pastEnd;
    logic    symbolBad;
    logic    hit;
    logic    lastSlot;
    logic    accept;
    logic    advance;
    logic    setFound;
    logic    setError;

    assign position  = offset + seqLenT'(index);
    assign pastEnd   = position >= lengthReg;
    assign symbolBad = !isBase(seqSymbol);
    assign hit       = (acceptMask & baseBit(seqSymbol)) != '0;
    assign lastSlot  = index == patAddrT'(PAT_DEPTH - 1);
    assign accept    = state == idle && start;

    // Addresses held steady through fetch so data is ready in compare
    assign seqReadAddr = position[SEQ_ADDR_W-1:0];
    assign patReadAddr = index;

    assign busy = state != idle;
    assign done = state == finish;

    // Decision order in compare: end token, bad token, sequence end,
    // bad symbol, mismatch, then advance
    always_comb begin
        nextState = state;
        advance   = 1'b0;
        setFound  = 1'b0;
        setError  = 1'b0;
        case (state)
            idle: begin
                if (start) begin
                    nextState = fetch;
                end
            end
            fetch: nextState = compare;
            compare: begin
                if (tokenKind == patEnd) begin
                    setFound  = 1'b1;
                    nextState = finish;
                end else if (malformed) begin
                    setError  = 1'b1;
                    nextState = finish;
                end else if (pastEnd) begin
                    nextState = finish;             // Not found
                end else if (symbolBad) begin
                    setError  = 1'b1;
                    nextState = finish;
                end else if (!hit) begin
                    nextState = nextOffset;
                end else if (lastSlot) begin
                    setError  = 1'b1;               // Pattern never closed
                    nextState = finish;
                end else begin
                    advance   = 1'b1;
                    nextState = fetch;
                end
            end
            nextOffset: nextState = fetch;
            finish: nextState = idle;
            default: nextState = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            lengthReg <= '0;
            offset    <= '0;
            index     <= '0;
        end else if (accept) begin
            lengthReg <= seqLength;
            offset    <= '0;
            index     <= '0;
        end else if (state == nextOffset) begin
            offset <= offset + 1'b1;
            index  <= '0;
        end else if (advance) begin
            index <= index + 1'b1;
        end
    end

    // Results land on entry to finish, so they are valid with done
    always_ff @(posedge clock) begin
        if (!reset_N) begin
            found       <= 1'b0;
            error       <= 1'b0;
            matchOffset <= '0;
        end else if (accept) begin
            found       <= 1'b0;
            error       <= 1'b0;
            matchOffset <= '0;
        end else begin
            if (setFound) begin
                found       <= 1'b1;
                matchOffset <= offset[SEQ_ADDR_W-1:0];
            end
            if (setError) begin
                error <= 1'b1;
            end
        end
    end

endmodule

//--- src/patternSearch.sv
module patternSearch import dnaPkg::*; (
    input  logic    clock,
    input  logic    reset_N,
    input  logic    start,
    input  seqLenT  seqLength,
    input  logic    seqWrite,
    input  seqAddrT seqAddr,
    input  baseT    seqData,
    input  logic    patWrite,
    input  patAddrT patAddr,
    input  tokenT   patData,
    output logic    busy,
    output logic    done,
    output logic    found,
    output logic    error,
    output seqAddrT matchOffset
);

    seqAddrT   seqReadAddr;
    baseT      seqSymbol;
    patAddrT   patReadAddr;
    tokenKindT tokenKind;
    baseMaskT  acceptMask;
    logic      malformed;

    symbolStore #(
        .payloadT(baseT)
    ) seqStore (
        .clock(clock),
        .write(seqWrite),
        .writeAddr(seqAddr),
        .writeData(seqData),
        .readAddr(seqReadAddr),
        .readData(seqSymbol)
    );

    tokenDecoder decoder (
        .clock(clock),
        .write(patWrite),
        .writeAddr(patAddr),
        .writeData(patData),
        .readAddr(patReadAddr),
        .tokenKind(tokenKind),
        .acceptMask(acceptMask),
        .malformed(malformed)
    );

    matchSequencer sequencer (
        .clock(clock),
        .reset_N(reset_N),
        .start(start),
        .seqLength(seqLength),
        .seqReadAddr(seqReadAddr),
        .seqSymbol(seqSymbol),
        .patReadAddr(patReadAddr),
        .tokenKind(tokenKind),
        .acceptMask(acceptMask),
        .malformed(malformed),
        .busy(busy),
        .done(done),
        .found(found),
        .error(error),
        .matchOffset(matchOffset)
    );

endmodule

//--- src/symbolStore.sv
module symbolStore import dnaPkg::*; #(
    parameter type payloadT = baseT
) (
    input  logic                                     clock,
    input  logic                                     write,
    input  logic [storeAddrBits($bits(payloadT))-1:0] writeAddr,
    input  payloadT                                  writeData,
    input  logic [storeAddrBits($bits(payloadT))-1:0] readAddr,
    output payloadT                                  readData
);

    payloadT mem [2**storeAddrBits($bits(payloadT))];

    always_ff @(posedge clock) begin
        if (write) begin
            mem[writeAddr] <= writeData;
        end
        readData <= mem[readAddr];                  // Old data on same-address write
    end

endmodule

//--- src/tokenDecoder.sv
module tokenDecoder import dnaPkg::*; (
    input  logic      clock,
    input  logic      write,
    input  patAddrT   writeAddr,
    input  tokenT     writeData,
    input  patAddrT   readAddr,
    output tokenKindT tokenKind,
    output baseMaskT  acceptMask,
    output logic      malformed
);

    tokenT    token;
    baseMaskT firstMask;
    baseMaskT secondMask;
    baseMaskT thirdMask;
    logic     firstBad;
    logic     secondBad;
    logic     thirdBad;
    logic     pairRepeat;
    logic     tripleRepeat;

    symbolStore #(
        .payloadT(tokenT)
    ) tokenStore (
        .clock(clock),
        .write(write),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .readAddr(readAddr),
        .readData(token)
    );

    assign firstMask  = baseBit(token.first);
    assign secondMask = baseBit(token.second);
    assign thirdMask  = baseBit(token.third);

    assign firstBad  = !isBase(token.first);
    assign secondBad = !isBase(token.second);
    assign thirdBad  = !isBase(token.third);

    assign pairRepeat   = token.first == token.second;
    assign tripleRepeat = pairRepeat || token.first == token.third
                          || token.second == token.third;

    assign tokenKind = token.kind;

    always_comb begin
        acceptMask = '0;
        malformed  = 1'b0;
        case (token.kind)
            literal: begin
                acceptMask = firstMask;
                malformed  = firstBad;
            end
            pairSet: begin
                acceptMask = firstMask | secondMask;
                malformed  = firstBad || secondBad || pairRepeat;
            end
            tripleSet: begin
                acceptMask = firstMask | secondMask | thirdMask;
                malformed  = firstBad || secondBad || thirdBad || tripleRepeat;
            end
            default: acceptMask = '0;               // End token accepts nothing
        endcase
    end

endmodule
